/* Makefile */
TOP = tb_sdram_scheduler

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module sdram_scheduler_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

/* design/sdram_command_issue.sv */
`include "sdram_consts.svh"

module sdram_command_issue
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  logic                   refresh_strobe,
  input  sdram_pkg::decode_t     decode,
  input  sdram_pkg::page_state_t page_state,
  output sdram_pkg::issue_t      issue
);
  import sdram_pkg::*;

  logic               refresh_ack;
  logic               refresh_pend;
  logic [`WAIT_W-1:0] wait_cnt;
  logic [`WAIT_W-1:0] wait_load;
  logic               second_stroke;
  logic               extra_pass;
  logic [`GUARD_W-1:0] actv_guard;
  logic [1:0]         grant_hold;   // Grant round trip to the port

  logic       guard_done;
  logic       hit_ok;
  logic       dir_match;
  logic       need_work;
  logic       wait_norm;
  logic       wait_long;
  logic       wr_recover;
  logic       fast_go;
  logic       slow_go;
  logic       issue_com;
  logic       rw_cmd;
  logic       arsr_go;
  sdram_bus_t bus_next;

  // --------------------------------------------------------------------
  // Command choice
  // --------------------------------------------------------------------
  assign guard_done = (actv_guard == `ACTV_GUARD);
  assign hit_ok     = (decode.hit_rand || decode.hit_bulk) &&
                      page_state.page_open && !refresh_pend;
  assign dir_match  = (decode.write == page_state.last_write);
  assign need_work  = decode.want_rand || decode.want_bulk || refresh_pend;
  assign wait_norm  = (wait_cnt >= `WAIT_READY);
  assign wait_long  = (wait_cnt == `WAIT_READY_WR);
  assign wr_recover = page_state.page_open && page_state.last_write && !hit_ok;

  always_comb
  begin
    bus_next.cmd     = NOOP;
    bus_next.address = '0;
    bus_next.bank    = '0;
    if (hit_ok)
    begin
      bus_next.cmd     = decode.write ? WRTE : READ;
      bus_next.address = {{(`ROW_W-`COL_W-1){1'b0}}, decode.column, 1'b0};
      bus_next.bank    = page_state.open_page.bank;
    end
    else if (page_state.page_open)
    begin
      if (guard_done)
        bus_next.cmd = PRCH;   // Row too young otherwise
      bus_next.address = `PRCH_ALL_ADDR;
      bus_next.bank    = page_state.open_page.bank;
    end
    else if (refresh_pend)
      bus_next.cmd = ARSR;
    else
    begin
      bus_next.cmd     = ACTV;
      bus_next.address = decode.target.row;
      bus_next.bank    = decode.target.bank;
    end
  end

  always_comb
  begin
    case (bus_next.cmd)
      ARSR:    wait_load = `WAIT_LOAD_ARSR;
      ACTV:    wait_load = `WAIT_LOAD_ACTV;
      PRCH:    wait_load = `WAIT_LOAD_PRCH;
      default: wait_load = `WAIT_LOAD_RW;
    endcase
  end

  assign rw_cmd    = (bus_next.cmd == READ) || (bus_next.cmd == WRTE);
  assign fast_go   = hit_ok && dir_match;   // Same direction skips the counter
  assign slow_go   = need_work && !extra_pass && (wr_recover ? wait_long : wait_norm);
  assign issue_com = second_stroke && (grant_hold == 2'd0) &&
                     (bus_next.cmd != NOOP) && (fast_go || slow_go);
  assign arsr_go   = issue_com && (bus_next.cmd == ARSR);

  // --------------------------------------------------------------------
  // Issue register and spacing state
  // --------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    issue.bus     <= bus_next;
    issue.we_mask <= decode.we_mask;
    if (RST)
    begin
      issue.valid      <= 1'b0;
      issue.grant_rand <= 1'b0;
      issue.grant_bulk <= 1'b0;
      second_stroke    <= 1'b1;
      grant_hold       <= 2'd0;
      refresh_ack      <= 1'b0;
      refresh_pend     <= 1'b0;
      wait_cnt         <= '1;    // Ready at once
      extra_pass       <= 1'b0;
      actv_guard       <= `ACTV_GUARD;
    end
    else
    begin
      issue.valid      <= issue_com;
      issue.grant_bulk <= issue_com && hit_ok && decode.hit_bulk;
      issue.grant_rand <= issue_com && hit_ok && decode.hit_rand;
      second_stroke    <= !issue_com;

      if (issue_com && rw_cmd)
        grant_hold <= 2'd3;
      else if (grant_hold != 2'd0)
        grant_hold <= grant_hold - 2'd1;

      if (arsr_go)
      begin
        refresh_ack  <= refresh_strobe;
        refresh_pend <= 1'b0;
      end
      else
        refresh_pend <= refresh_strobe ^ refresh_ack;

      // Refresh takes two passes of the counter
      if (issue_com)
        wait_cnt <= wait_load;
      else if (extra_pass && wait_norm)
        wait_cnt <= `WAIT_LOAD_ARSR;
      else if (!wait_long)
        wait_cnt <= wait_cnt + 1'b1;

      if (arsr_go)
        extra_pass <= 1'b1;
      else if (extra_pass && wait_norm)
        extra_pass <= 1'b0;

      if (issue_com && (bus_next.cmd == ACTV))
        actv_guard <= '0;
      else if (!guard_done)
        actv_guard <= actv_guard + 1'b1;
    end
  end

  a_grant_with_access: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (issue.grant_rand || issue.grant_bulk) |->
      issue.valid && (issue.bus.cmd inside {READ, WRTE}));

  a_single_grant: assert property (@(posedge INPUT_CLK) disable iff (RST)
    !(issue.grant_rand && issue.grant_bulk));

endmodule

/* design/sdram_command_register.sv */
`include "sdram_consts.svh"

module sdram_command_register
(
  input  logic                    INPUT_CLK,
  input  logic                    RST,
  input  sdram_pkg::issue_t       issue,
  output sdram_pkg::sdram_bus_t   sdram_bus,
  output logic                    grant_rand,
  output logic                    grant_bulk,
  output logic [`MASK_W-1:0]      we_mask,
  output sdram_pkg::page_state_t  page_state
);
  import sdram_pkg::*;

  // --------------------------------------------------------------------
  // Command bus, grants and mask
  // --------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    sdram_bus.address <= issue.bus.address;
    sdram_bus.bank    <= issue.bus.bank;
    we_mask           <= issue.we_mask;
    if (RST)
    begin
      sdram_bus.cmd <= NOOP;
      grant_rand    <= 1'b0;
      grant_bulk    <= 1'b0;
    end
    else
    begin
      sdram_bus.cmd <= issue.valid ? issue.bus.cmd : NOOP;
      grant_rand    <= issue.valid && issue.grant_rand;
      grant_bulk    <= issue.valid && issue.grant_bulk;
    end
  end

  // --------------------------------------------------------------------
  // Open page tracking
  // --------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_state.page_open  <= 1'b0;
      page_state.last_write <= 1'b0;
    end
    else if (issue.valid)
    begin
      case (issue.bus.cmd)
        ACTV:
        begin
          page_state.page_open      <= 1'b1;
          page_state.open_page.row  <= issue.bus.address;  // Row on the bus
          page_state.open_page.bank <= issue.bus.bank;
        end
        PRCH:
          page_state.page_open <= 1'b0;
        READ:
          page_state.last_write <= 1'b0;
        WRTE:
          page_state.last_write <= 1'b1;
        default:
          page_state.page_open <= page_state.page_open;
      endcase
    end
  end

  // The tracked page lags the issue stage by one register
  a_no_actv_on_open: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (issue.valid && (issue.bus.cmd == ACTV)) |-> !page_state.page_open);

endmodule

/* design/sdram_consts.svh */
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// --------------------------------------------------------------------
// Port and bus widths
// --------------------------------------------------------------------
`define ADDR_W 26
`define ROW_W 14
`define BANK_W 3
`define COL_W 9
`define MASK_W 4

// Bit 10 set selects all banks
`define PRCH_ALL_ADDR 14'h0400

// --------------------------------------------------------------------
// Command spacing
// --------------------------------------------------------------------
`define WAIT_W 4
`define WAIT_LOAD_ARSR 4'd3
`define WAIT_LOAD_ACTV 4'd12
`define WAIT_LOAD_RW 4'd11
`define WAIT_LOAD_PRCH 4'd11
`define WAIT_READY 4'd13      // Normal spacing met
`define WAIT_READY_WR 4'd15   // Write recovery before PRCH

`define GUARD_W 3
`define ACTV_GUARD 3'd4       // ACTV to PRCH of same row

`endif

/* design/sdram_pkg.sv */
`include "sdram_consts.svh"

package sdram_pkg;

  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } sdram_cmd_t;

  typedef struct packed {
    logic                request;
    logic                write;
    logic [`ADDR_W-1:0]  addr;
    logic [`MASK_W-1:0]  we_mask;
  } port_req_t;

  typedef struct packed {
    logic [`ROW_W-1:0]   row;
    logic [`BANK_W-1:0]  bank;
  } page_t;

  typedef struct packed {
    logic                page_open;
    page_t               open_page;
    logic                last_write;  // Last access was a write
  } page_state_t;

  // Fields below hit_* and want_* belong to the selected port
  typedef struct packed {
    logic                hit_rand;
    logic                hit_bulk;
    logic                want_rand;
    logic                want_bulk;
    logic                write;
    page_t               target;
    logic [`COL_W-1:0]   column;
    logic [`MASK_W-1:0]  we_mask;
  } decode_t;

  typedef struct packed {
    sdram_cmd_t          cmd;
    logic [`ROW_W-1:0]   address;
    logic [`BANK_W-1:0]  bank;
  } sdram_bus_t;

  typedef struct packed {
    logic                valid;
    sdram_bus_t          bus;
    logic                grant_rand;
    logic                grant_bulk;
    logic [`MASK_W-1:0]  we_mask;
  } issue_t;

endpackage

/* design/sdram_request_decode.sv */
`include "sdram_consts.svh"

module sdram_request_decode
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  sdram_pkg::port_req_t   rand_port,
  input  sdram_pkg::port_req_t   bulk_port,
  input  sdram_pkg::page_state_t page_state,
  output sdram_pkg::decode_t     decode
);
  import sdram_pkg::*;

  port_req_t rand_q;
  port_req_t bulk_q;
  port_req_t sel;
  page_t     rand_page;
  page_t     bulk_page;
  logic      hit_rand_w;
  logic      hit_bulk_w;
  logic      hit_rand_q;
  logic      hit_bulk_q;

  // Row and bank sit above the column bits
  function automatic page_t addr_page(input logic [`ADDR_W-1:0] addr);
    page_t p;
    p.row  = addr[`ADDR_W-1 -: `ROW_W];
    p.bank = addr[`COL_W +: `BANK_W];
    return p;
  endfunction

  // --------------------------------------------------------------------
  // Page compare on the live ports
  // --------------------------------------------------------------------
  assign rand_page = addr_page(rand_port.addr);
  assign bulk_page = addr_page(bulk_port.addr);

  assign hit_rand_w = rand_port.request && !bulk_port.request &&  // Bulk first
                      page_state.page_open &&
                      (rand_page == page_state.open_page);

  assign hit_bulk_w = bulk_port.request &&
                      page_state.page_open &&
                      (bulk_page == page_state.open_page);

  always_ff @(posedge INPUT_CLK)
  begin
    rand_q <= rand_port;
    bulk_q <= bulk_port;
    if (RST)
    begin
      rand_q.request <= 1'b0;
      bulk_q.request <= 1'b0;
      hit_rand_q     <= 1'b0;
      hit_bulk_q     <= 1'b0;
    end
    else
    begin
      hit_rand_q <= hit_rand_w;
      hit_bulk_q <= hit_bulk_w;
    end
  end

  // --------------------------------------------------------------------
  // Port select
  // --------------------------------------------------------------------
  assign sel = bulk_q.request ? bulk_q : rand_q;

  always_comb
  begin
    decode.hit_rand  = hit_rand_q;
    decode.hit_bulk  = hit_bulk_q;
    decode.want_rand = rand_q.request;
    decode.want_bulk = bulk_q.request;
    decode.write     = sel.write;
    decode.target    = addr_page(sel.addr);
    decode.column    = sel.addr[`COL_W-1:0];
    decode.we_mask   = sel.we_mask;
  end

endmodule

/* design/sdram_scheduler_top.sv */
`include "sdram_consts.svh"

module sdram_scheduler_top
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  logic                   refresh_strobe,
  input  sdram_pkg::port_req_t   rand_port,
  input  sdram_pkg::port_req_t   bulk_port,
  output sdram_pkg::sdram_bus_t  sdram_bus,
  output logic                   grant_rand,
  output logic                   grant_bulk,
  output logic [`MASK_W-1:0]     we_mask
);
  import sdram_pkg::*;

  decode_t     decode;
  issue_t      issue;
  page_state_t page_state;   // Fed back to decode and issue

  sdram_request_decode u_decode
  (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .rand_port  (rand_port),
    .bulk_port  (bulk_port),
    .page_state (page_state),
    .decode     (decode)
  );

  sdram_command_issue u_issue
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .decode         (decode),
    .page_state     (page_state),
    .issue          (issue)
  );

  sdram_command_register u_register
  (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issue      (issue),
    .sdram_bus  (sdram_bus),
    .grant_rand (grant_rand),
    .grant_bulk (grant_bulk),
    .we_mask    (we_mask),
    .page_state (page_state)
  );

endmodule

/* list.f */
+incdir+design
design/sdram_pkg.sv
design/sdram_request_decode.sv
design/sdram_command_issue.sv
design/sdram_command_register.sv
design/sdram_scheduler_top.sv
tests/tb_sdram_scheduler.sv

/* tests/tb_sdram_scheduler.sv */
`include "sdram_consts.svh"

module tb_sdram_scheduler;
  import sdram_pkg::*;

  localparam int TIMEOUT = 200;

  logic               INPUT_CLK;
  logic               RST;
  logic               refresh_strobe;
  port_req_t          rand_port;
  port_req_t          bulk_port;
  sdram_bus_t         sdram_bus;
  logic               grant_rand;
  logic               grant_bulk;
  logic [`MASK_W-1:0] we_mask;

  integer     seed;
  int         error_count;
  int         cycle_no = 0;
  page_t      open_page;     // Page the model expects open
  sdram_bus_t cmd_log[$];
  int         cmd_cycle[$];

  sdram_scheduler_top UUT (.*);

  always #50 INPUT_CLK = ~INPUT_CLK;

  // Bus monitor, sees the value held over the previous cycle
  always @(posedge INPUT_CLK)
  begin
    cycle_no = cycle_no + 1;
    if (!RST && (sdram_bus.cmd != NOOP))
    begin
      cmd_log.push_back(sdram_bus);
      cmd_cycle.push_back(cycle_no);
    end
  end

  // ----------------------------------------------------------------------
  // Reporting and compares
  // ----------------------------------------------------------------------
  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bus(input string name, input sdram_bus_t exp, input sdram_bus_t act);
    logic bad;
    bad = (act.cmd !== exp.cmd);
    if (exp.cmd inside {ACTV, READ, WRTE, PRCH})  // Address carried
      bad = bad || (act.address !== exp.address);
    if (exp.cmd inside {ACTV, READ, WRTE})        // Bank carried
      bad = bad || (act.bank !== exp.bank);
    if (bad)
      report_failure($sformatf(
        "FAIL time %0t %s expected %s addr=%h bank=%h actual %s addr=%h bank=%h",
        $time, name, exp.cmd.name(), exp.address, exp.bank,
        act.cmd.name(), act.address, act.bank));
  endtask

  task automatic check_grant(input logic exp_rand, input logic exp_bulk,
                             input logic [`MASK_W-1:0] exp_mask);
    if (grant_rand !== exp_rand)
      report_failure($sformatf("FAIL time %0t grant_rand expected %b actual %b",
        $time, exp_rand, grant_rand));
    if (grant_bulk !== exp_bulk)
      report_failure($sformatf("FAIL time %0t grant_bulk expected %b actual %b",
        $time, exp_bulk, grant_bulk));
    if ((exp_rand || exp_bulk) && (we_mask !== exp_mask))
      report_failure($sformatf("FAIL time %0t we_mask expected %h actual %h",
        $time, exp_mask, we_mask));
  endtask

  task automatic check_log(input int idx, input sdram_bus_t exp);
    if (idx >= cmd_log.size())
      report_failure($sformatf("The command log ends before entry %0d, which should be %s",
        idx, exp.cmd.name()));
    else
      check_bus($sformatf("sdram_bus log[%0d]", idx), exp, cmd_log[idx]);
  endtask

  task automatic check_count(input int mark, input int n);
    if (cmd_log.size() - mark != n)
      report_failure($sformatf("Expected %0d bus commands for this access but %0d were logged",
        n, cmd_log.size() - mark));
  endtask

  task automatic check_spacing();
    for (int i = 1; i < cmd_log.size(); i++)
      if (cmd_cycle[i] - cmd_cycle[i-1] < 2)
        report_failure($sformatf("Commands %s and %s came in back to back cycles",
          cmd_log[i-1].cmd.name(), cmd_log[i].cmd.name()));
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  // Any row differing from the page to avoid
  function automatic page_t random_page(input page_t avoid);
    logic [31:0] r;
    page_t       p;
    r = random_word();
    p.row  = r[`ROW_W-1:0];
    p.bank = r[`ROW_W +: `BANK_W];
    if (p.row == avoid.row)
      p.row = ~p.row;
    return p;
  endfunction

  function automatic port_req_t make_req(input logic write, input page_t pg);
    logic [31:0] r;
    port_req_t   q;
    r = random_word();
    q.request = 1'b1;
    q.write   = write;
    q.addr    = {pg.row, pg.bank, r[`COL_W-1:0]};  // Row, bank, column
    q.we_mask = r[`COL_W +: `MASK_W];
    return q;
  endfunction

  function automatic sdram_bus_t bus_word(input sdram_cmd_t cmd,
                                          input logic [`ROW_W-1:0] address,
                                          input logic [`BANK_W-1:0] bank);
    sdram_bus_t b;
    b.cmd     = cmd;
    b.address = address;
    b.bank    = bank;
    return b;
  endfunction

  // Column moves up one bit on the bus
  function automatic logic [`ROW_W-1:0] col_address(input port_req_t q);
    logic [`ROW_W-1:0] wide;
    wide = '0;
    wide[`COL_W-1:0] = q.addr[`COL_W-1:0];
    return wide << 1;
  endfunction

  task automatic drive_port(input logic bulk, input port_req_t q);
    if (bulk)
      bulk_port = q;
    else
      rand_port = q;
  endtask

  task automatic wait_any_grant(input string what);
    int n;
    n = 0;
    while (!(grant_rand || grant_bulk))
    begin
      @(negedge INPUT_CLK);
      n++;
      if (n > TIMEOUT)
        report_failure($sformatf("Timeout, the %s grant never came", what));
    end
  endtask

  // Checks the grant pulse and its access command, then withdraws the request
  task automatic finish_grant(input logic bulk, input port_req_t q, input page_t pg);
    sdram_cmd_t access_cmd;
    access_cmd = q.write ? WRTE : READ;
    check_grant(!bulk, bulk, q.we_mask);
    check_bus("sdram_bus", bus_word(access_cmd, col_address(q), pg.bank), sdram_bus);
    @(negedge INPUT_CLK);
    q.request = 1'b0;
    drive_port(bulk, q);
    check_grant(1'b0, 1'b0, '0);
  endtask

  task automatic access(input logic bulk, input port_req_t q, input page_t pg,
                        input string what);
    @(negedge INPUT_CLK);
    drive_port(bulk, q);
    wait_any_grant(what);
    finish_grant(bulk, q, pg);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic idle_after_reset();
    repeat (6)
    begin
      @(negedge INPUT_CLK);
      check_bus("sdram_bus", bus_word(NOOP, '0, '0), sdram_bus);
      check_grant(1'b0, 1'b0, '0);
    end
    if (cmd_log.size() != 0)
      report_failure("Commands appeared on the bus while no port was requesting");
  endtask

  task automatic read_closed_bank();
    page_t     pg;
    port_req_t q;
    int        mark;
    pg   = random_page(open_page);
    q    = make_req(1'b0, pg);
    mark = cmd_log.size();
    access(1'b0, q, pg, "random port");
    check_count(mark, 2);
    check_log(mark, bus_word(ACTV, pg.row, pg.bank));
    check_log(mark + 1, bus_word(READ, col_address(q), pg.bank));
    open_page = pg;
  endtask

  task automatic write_page_hit();
    port_req_t q;
    int        mark;
    q    = make_req(1'b1, open_page);
    mark = cmd_log.size();
    access(1'b0, q, open_page, "random port");
    check_count(mark, 1);  // No ACTV or PRCH first
    check_log(mark, bus_word(WRTE, col_address(q), open_page.bank));
  endtask

  task automatic read_page_miss();
    page_t     pg;
    port_req_t q;
    int        mark;
    pg   = random_page(open_page);
    q    = make_req(1'b0, pg);
    mark = cmd_log.size();
    access(1'b1, q, pg, "bulk port");
    check_count(mark, 3);
    check_log(mark, bus_word(PRCH, `PRCH_ALL_ADDR, '0));
    check_log(mark + 1, bus_word(ACTV, pg.row, pg.bank));
    check_log(mark + 2, bus_word(READ, col_address(q), pg.bank));
    check_spacing();
    open_page = pg;
  endtask

  task automatic bulk_before_random();
    page_t     pg_bulk;
    page_t     pg_rand;
    port_req_t q_bulk;
    port_req_t q_rand;
    int        mark;
    pg_bulk = random_page(open_page);
    pg_rand = random_page(pg_bulk);
    q_bulk  = make_req(1'b0, pg_bulk);
    q_rand  = make_req(1'b0, pg_rand);
    mark    = cmd_log.size();
    @(negedge INPUT_CLK);
    drive_port(1'b0, q_rand);
    drive_port(1'b1, q_bulk);
    wait_any_grant("bulk port");
    finish_grant(1'b1, q_bulk, pg_bulk);  // Bulk must win
    wait_any_grant("random port");
    finish_grant(1'b0, q_rand, pg_rand);
    check_log(mark + 1, bus_word(ACTV, pg_bulk.row, pg_bulk.bank));
    check_log(mark + 4, bus_word(ACTV, pg_rand.row, pg_rand.bank));
    open_page = pg_rand;
  endtask

  task automatic refresh_open_page();
    page_t     pg;
    port_req_t q;
    int        mark;
    int        n;
    mark = cmd_log.size();
    @(negedge INPUT_CLK);
    refresh_strobe = ~refresh_strobe;
    n = 0;
    while (cmd_log.size() < mark + 2)
    begin
      @(negedge INPUT_CLK);
      n++;
      if (n > TIMEOUT)
        report_failure("Timeout, no precharge and refresh followed the strobe toggle");
    end
    check_log(mark, bus_word(PRCH, `PRCH_ALL_ADDR, '0));
    check_log(mark + 1, bus_word(ARSR, '0, '0));
    pg   = random_page(open_page);
    q    = make_req(1'b0, pg);
    mark = cmd_log.size();
    access(1'b0, q, pg, "random port after refresh");
    check_log(mark, bus_word(ACTV, pg.row, pg.bank));  // Bank closed by refresh
    open_page = pg;
  endtask

  initial
  begin
    seed           = 78;
    error_count    = 0;
    INPUT_CLK      = 1'b0;
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_port      = '0;
    bulk_port      = '0;
    open_page      = '0;
    repeat (16) @(negedge INPUT_CLK);
    RST = 1'b0;
    idle_after_reset();
    read_closed_bank();
    write_page_hit();
    read_page_miss();
    bulk_before_random();
    refresh_open_page();
    check_spacing();
    if (error_count == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      report_failure("Errors were counted during the run");
  end

endmodule
